// ==== logic/sys_pkg.sv ====
`default_nettype none

package sys_pkg;

  // ************************************************************
  // widths and encodings
  // ************************************************************
  localparam int xlen = 64;

  localparam logic [6:0] opc_system = 7'b1110011;

  // funct3 under the system opcode
  localparam logic [2:0] f3_priv   = 3'b000;
  localparam logic [2:0] f3_csrrw  = 3'b001;
  localparam logic [2:0] f3_csrrs  = 3'b010;
  localparam logic [2:0] f3_csrrc  = 3'b011;
  localparam logic [2:0] f3_csrrwi = 3'b101;
  localparam logic [2:0] f3_csrrsi = 3'b110;
  localparam logic [2:0] f3_csrrci = 3'b111;

  // funct12 for privileged forms
  localparam logic [11:0] f12_ecall = 12'h000;
  localparam logic [11:0] f12_mret  = 12'h302;

  // machine-mode csr addresses
  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;

  // environment call from m-mode
  localparam logic [63:0] cause_ecall_m = 64'd11;

  // ************************************************************
  // mstatus layout, reset and masks
  // ************************************************************
  // mpp = 2'b11, uxl and sxl = 2'b10
  localparam logic [63:0] mstatus_reset = 64'h0000_000A_0000_1800;
  localparam int          mstatus_mie   = 3;
  localparam int          mstatus_mpie  = 7;
  // only mie and mpie writable
  localparam logic [63:0] mstatus_wmask = 64'h0000_0000_0000_0088;
  // direct mode only, low two bits stay zero
  localparam logic [63:0] align_mask    = 64'hFFFF_FFFF_FFFF_FFFC;

  typedef enum logic [1:0] {
    op_rw  = 2'd0,
    op_set = 2'd1,
    op_clr = 2'd2
  } csr_op_e;

  // same word seen as csr form or privileged form
  typedef union packed {
    struct packed {
      logic [11:0] csr;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } csr_fmt;
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } priv_fmt;
  } sys_inst_u;

endpackage

`default_nettype wire

// ==== logic/csr_op_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface csr_op_if;

  // at most one of these three per cycle
  logic                        csr_valid;
  logic                        ecall;
  logic                        mret;
  // csr operation payload
  sys_pkg::csr_op_e            op;
  logic [11:0]                 addr;
  // rs1_data or zero-extended zimm
  logic [sys_pkg::xlen-1:0]    src;
  // rs1 field is zero
  logic                        src_is_zero;

  // decoder side
  modport dec (
    output csr_valid, ecall, mret, op, addr, src, src_is_zero
  );

  // alu and csr file side
  modport csr (
    input csr_valid, ecall, mret, op, addr, src, src_is_zero
  );

endinterface

`default_nettype wire

// ==== logic/sys_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module sys_decode (
  input  sys_pkg::sys_inst_u        inst,
  input  logic                      valid,
  input  logic [sys_pkg::xlen-1:0]  rs1_data,
  csr_op_if.dec                     op,
  output logic                      illegal,
  output logic                      rd_zero
);

  logic [11:0] funct12;
  logic [2:0]  funct3;
  logic        is_system;
  logic        addr_known;

  // funct12 is funct7 and rs2 of the privileged form
  assign funct12   = {inst.priv_fmt.funct7, inst.priv_fmt.rs2};
  assign funct3    = inst.csr_fmt.funct3;
  assign is_system = (inst.csr_fmt.opcode == sys_pkg::opc_system);

  // implemented csr set
  always_comb begin
    case (inst.csr_fmt.csr)
      sys_pkg::csr_mstatus,
      sys_pkg::csr_mtvec,
      sys_pkg::csr_mepc,
      sys_pkg::csr_mcause: addr_known = 1'b1;
      default:             addr_known = 1'b0;
    endcase
  end

  // ************************************************************
  // payload, no gating needed
  // ************************************************************
  assign op.addr        = inst.csr_fmt.csr;
  assign op.src_is_zero = (inst.csr_fmt.rs1 == 5'd0);
  // immediate forms have funct3[2] set
  assign op.src         = funct3[2] ? {{(sys_pkg::xlen-5){1'b0}}, inst.csr_fmt.rs1}
                                    : rs1_data;
  assign rd_zero        = (inst.csr_fmt.rd == 5'd0);

  // kind from low funct3 bits
  always_comb begin
    case (funct3[1:0])
      2'b10:   op.op = sys_pkg::op_set;
      2'b11:   op.op = sys_pkg::op_clr;
      default: op.op = sys_pkg::op_rw;
    endcase
  end

  // ************************************************************
  // control flags, all low when not valid
  // ************************************************************
  always_comb begin
    op.csr_valid = 1'b0;
    op.ecall     = 1'b0;
    op.mret      = 1'b0;
    illegal      = 1'b0;
    if (valid) begin
      if (!is_system) begin
        illegal = 1'b1;
      end else begin
        case (funct3)
          sys_pkg::f3_priv: begin
            // ecall or mret by funct12
            if (funct12 == sys_pkg::f12_ecall) begin
              op.ecall = 1'b1;
            end else if (funct12 == sys_pkg::f12_mret) begin
              op.mret = 1'b1;
            end else begin
              illegal = 1'b1;
            end
          end
          sys_pkg::f3_csrrw,  sys_pkg::f3_csrrs,  sys_pkg::f3_csrrc,
          sys_pkg::f3_csrrwi, sys_pkg::f3_csrrsi, sys_pkg::f3_csrrci: begin
            // unimplemented address traps as illegal
            if (addr_known) begin
              op.csr_valid = 1'b1;
            end else begin
              illegal = 1'b1;
            end
          end
          // 3'b100 reserved
          default: illegal = 1'b1;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/csr_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_alu (
  csr_op_if.csr                     op,
  input  logic [sys_pkg::xlen-1:0]  old_value,
  output logic [sys_pkg::xlen-1:0]  new_value,
  output logic                      do_write
);

  // ************************************************************
  // new value per operation kind
  // ************************************************************
  always_comb begin
    case (op.op)
      // set bits named by src
      sys_pkg::op_set: new_value = old_value | op.src;
      // clear bits named by src
      sys_pkg::op_clr: new_value = old_value & ~op.src;
      // plain replace
      default:         new_value = op.src;
    endcase
  end

  // set/clear with x0 or zimm 0 is a pure read
  always_comb begin
    if (!op.csr_valid) begin
      do_write = 1'b0;
    end else if (op.op == sys_pkg::op_rw) begin
      do_write = 1'b1;
    end else begin
      do_write = !op.src_is_zero;
    end
  end

endmodule

`default_nettype wire

// ==== logic/csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file (
  input  logic                      clk,
  input  logic                      rst_n,
  csr_op_if.csr                     op,
  input  logic [sys_pkg::xlen-1:0]  pc,
  input  logic [sys_pkg::xlen-1:0]  new_value,
  input  logic                      do_write,
  output logic [sys_pkg::xlen-1:0]  old_value,
  output logic                      redirect,
  output logic [sys_pkg::xlen-1:0]  redirect_pc,
  output logic [sys_pkg::xlen-1:0]  mstatus,
  output logic [sys_pkg::xlen-1:0]  mtvec,
  output logic [sys_pkg::xlen-1:0]  mepc,
  output logic [sys_pkg::xlen-1:0]  mcause
);

  logic wr_mstatus;
  logic wr_mtvec;
  logic wr_mepc;
  logic wr_mcause;

  // per-register write strobes
  assign wr_mstatus = do_write && (op.addr == sys_pkg::csr_mstatus);
  assign wr_mtvec   = do_write && (op.addr == sys_pkg::csr_mtvec);
  assign wr_mepc    = do_write && (op.addr == sys_pkg::csr_mepc);
  assign wr_mcause  = do_write && (op.addr == sys_pkg::csr_mcause);

  // ************************************************************
  // read select
  // ************************************************************
  always_comb begin
    case (op.addr)
      sys_pkg::csr_mstatus: old_value = mstatus;
      sys_pkg::csr_mtvec:   old_value = mtvec;
      sys_pkg::csr_mepc:    old_value = mepc;
      sys_pkg::csr_mcause:  old_value = mcause;
      default:              old_value = '0;
    endcase
  end

  // ************************************************************
  // mtvec, base address of the trap handler
  // ************************************************************
  always_ff @(posedge clk) begin
    if (rst_n) begin
      mtvec <= '0;
    end else if (wr_mtvec) begin
      mtvec <= new_value & sys_pkg::align_mask;
    end
  end

  // mepc, pc of the trapping instruction
  always_ff @(posedge clk) begin
    if (rst_n) begin
      mepc <= '0;
    end else if (op.ecall) begin
      mepc <= pc;
    end else if (wr_mepc) begin
      mepc <= new_value & sys_pkg::align_mask;
    end
  end

  // mcause, only ecall is raised here
  always_ff @(posedge clk) begin
    if (rst_n) begin
      mcause <= '0;
    end else if (op.ecall) begin
      mcause <= sys_pkg::cause_ecall_m;
    end else if (wr_mcause) begin
      mcause <= new_value;
    end
  end

  // ************************************************************
  // mstatus, mie/mpie stack
  // ************************************************************
  always_ff @(posedge clk) begin
    if (rst_n) begin
      mstatus <= sys_pkg::mstatus_reset;
    end else if (op.ecall) begin
      // push mie into mpie, disable
      mstatus[sys_pkg::mstatus_mpie] <= mstatus[sys_pkg::mstatus_mie];
      mstatus[sys_pkg::mstatus_mie]  <= 1'b0;
    end else if (op.mret) begin
      // pop mpie back into mie
      mstatus[sys_pkg::mstatus_mie]  <= mstatus[sys_pkg::mstatus_mpie];
      mstatus[sys_pkg::mstatus_mpie] <= 1'b1;
    end else if (wr_mstatus) begin
      // fixed fields keep their value
      mstatus <= (mstatus & ~sys_pkg::mstatus_wmask)
               | (new_value & sys_pkg::mstatus_wmask);
    end
  end

  // redirect target, ecall to mtvec and mret to mepc
  assign redirect = op.ecall || op.mret;

  always_comb begin
    if (op.ecall) begin
      redirect_pc = mtvec;
    end else if (op.mret) begin
      redirect_pc = mepc;
    end else begin
      redirect_pc = '0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/sys_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sys_unit_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      valid,
  input  logic [31:0]               inst,
  input  logic [sys_pkg::xlen-1:0]  pc,
  input  logic [sys_pkg::xlen-1:0]  rs1_data,
  output logic [sys_pkg::xlen-1:0]  rd_data,
  output logic                      rd_wen,
  output logic                      redirect,
  output logic [sys_pkg::xlen-1:0]  redirect_pc,
  output logic                      illegal,
  // debug view for the difference checker
  output logic [sys_pkg::xlen-1:0]  mstatus,
  output logic [sys_pkg::xlen-1:0]  mtvec,
  output logic [sys_pkg::xlen-1:0]  mepc,
  output logic [sys_pkg::xlen-1:0]  mcause
);

  logic [sys_pkg::xlen-1:0] old_value;
  logic [sys_pkg::xlen-1:0] new_value;
  logic                     do_write;
  logic                     rd_zero;

  csr_op_if op_bus ();

  // ************************************************************
  // decode, modify, commit
  // ************************************************************
  sys_decode u_decode (
    .inst     (inst),
    .valid    (valid),
    .rs1_data (rs1_data),
    .op       (op_bus),
    .illegal  (illegal),
    .rd_zero  (rd_zero)
  );

  csr_alu u_alu (
    .op        (op_bus),
    .old_value (old_value),
    .new_value (new_value),
    .do_write  (do_write)
  );

  csr_file u_csr (
    .clk         (clk),
    .rst_n       (rst_n),
    .op          (op_bus),
    .pc          (pc),
    .new_value   (new_value),
    .do_write    (do_write),
    .old_value   (old_value),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .mstatus     (mstatus),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .mcause      (mcause)
  );

  // old csr value goes to rd, x0 never written
  assign rd_data = old_value;
  assign rd_wen  = op_bus.csr_valid && !rd_zero;

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // reset is active high, held for two rising edges
  initial begin
    rst_n = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b0;
  end

endmodule

`default_nettype wire

// ==== test/tb_sys_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sys_unit;

  logic        clk;
  logic        rst_n;
  logic        valid;
  logic [31:0] inst;
  logic [63:0] pc;
  logic [63:0] rs1_data;
  logic [63:0] rd_data;
  logic        rd_wen;
  logic        redirect;
  logic [63:0] redirect_pc;
  logic        illegal;
  logic [63:0] mstatus;
  logic [63:0] mtvec;
  logic [63:0] mepc;
  logic [63:0] mcause;

  logic [31:0] seed;
  int          errors;
  int          checks;
  int          tests;
  int          failed_tests;

  tb_clock u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  sys_unit_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid       (valid),
    .inst        (inst),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .rd_data     (rd_data),
    .rd_wen      (rd_wen),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .illegal     (illegal),
    .mstatus     (mstatus),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .mcause      (mcause)
  );

  // ************************************************************
  // random source
  // ************************************************************
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] rand32();
    seed = xorshift(seed);
    return seed;
  endfunction

  // kinds: 0 csr, 1 probe, 2 ecall, 3 mret, 4 illegal, 5 mix, 6 idle
  function automatic int pick_kind();
    logic [31:0] r;
    r = rand32();
    if (r[3:0] <= 4'd8) return 0;
    if (r[3:0] <= 4'd10) return 1;
    if (r[3:0] <= 4'd12) return 2;
    if (r[3:0] <= 4'd14) return 3;
    return 4;
  endfunction

  function automatic logic [31:0] make_inst(input int kind);
    logic [31:0] r;
    logic [11:0] addr;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1f;
    r = rand32();
    case (r[1:0])
      2'd0:    addr = sys_pkg::csr_mstatus;
      2'd1:    addr = sys_pkg::csr_mtvec;
      2'd2:    addr = sys_pkg::csr_mepc;
      default: addr = sys_pkg::csr_mcause;
    endcase
    // rd of zero about one time in eight
    rd   = (r[4:2] == 3'd0) ? 5'd0 : r[9:5];
    rs1f = r[14:10];
    f3   = r[17:15];
    if (f3 == sys_pkg::f3_priv) f3 = sys_pkg::f3_csrrw;
    if (f3 == 3'b100) f3 = sys_pkg::f3_csrrwi;
    if (kind == 1) begin
      // csrrs, csrrc, csrrsi, csrrci with zero source
      f3   = {r[18], 1'b1, r[19]};
      rs1f = 5'd0;
    end else if (kind == 2) begin
      return {sys_pkg::f12_ecall, 5'd0, sys_pkg::f3_priv, 5'd0, sys_pkg::opc_system};
    end else if (kind == 3) begin
      return {sys_pkg::f12_mret, 5'd0, sys_pkg::f3_priv, 5'd0, sys_pkg::opc_system};
    end else if (kind == 4) begin
      case (r[20:19])
        // reserved funct3
        2'd0: f3 = 3'b100;
        // odd funct12, never ecall or mret
        2'd1: return {r[31:21], 1'b1, 5'd0, sys_pkg::f3_priv, 5'd0, sys_pkg::opc_system};
        // counter space, not implemented
        2'd2: addr = {4'hC, r[31:24]};
        default: return {r[31:7], 7'b0110011};
      endcase
    end else if (kind != 0) begin
      return r;
    end
    return {addr, rs1f, f3, rd, sys_pkg::opc_system};
  endfunction

  // ************************************************************
  // reference model, state order mstatus mtvec mepc mcause
  // ************************************************************
  function automatic void predict(
    input  logic            v,
    input  logic [31:0]     ins,
    input  logic [63:0]     pc_in,
    input  logic [63:0]     rs1,
    input  logic [3:0][63:0] st,
    output logic [3:0][63:0] nx,
    output logic [63:0]     e_rd,
    output logic            e_wen,
    output logic            e_redir,
    output logic [63:0]     e_rpc,
    output logic            e_ill,
    output logic            e_csr
  );
    logic [6:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1f;
    logic [2:0]  f3;
    logic [11:0] f12;
    logic [63:0] src;
    logic [63:0] old;
    logic [63:0] upd;
    logic [1:0]  idx;
    logic        idx_ok;
    opcode  = ins[6:0];
    rd      = ins[11:7];
    f3      = ins[14:12];
    rs1f    = ins[19:15];
    f12     = ins[31:20];
    nx      = st;
    e_rd    = 64'd0;
    e_wen   = 1'b0;
    e_redir = 1'b0;
    e_rpc   = 64'd0;
    e_ill   = 1'b0;
    e_csr   = 1'b0;
    idx_ok  = 1'b1;
    idx     = 2'd0;
    case (f12)
      sys_pkg::csr_mstatus: idx = 2'd0;
      sys_pkg::csr_mtvec:   idx = 2'd1;
      sys_pkg::csr_mepc:    idx = 2'd2;
      sys_pkg::csr_mcause:  idx = 2'd3;
      default:              idx_ok = 1'b0;
    endcase
    if (v) begin
      if (opcode != sys_pkg::opc_system || f3 == 3'b100) begin
        e_ill = 1'b1;
      end else if (f3 == sys_pkg::f3_priv) begin
        if (f12 == sys_pkg::f12_ecall) begin
          // trap entry, jump to handler base
          e_redir  = 1'b1;
          e_rpc    = st[1];
          nx[2]    = pc_in;
          nx[3]    = 64'd11;
          nx[0][7] = st[0][3];
          nx[0][3] = 1'b0;
        end else if (f12 == sys_pkg::f12_mret) begin
          e_redir  = 1'b1;
          e_rpc    = st[2];
          nx[0][3] = st[0][7];
          nx[0][7] = 1'b1;
        end else begin
          e_ill = 1'b1;
        end
      end else if (!idx_ok) begin
        e_ill = 1'b1;
      end else begin
        e_csr = 1'b1;
        old   = st[idx];
        e_rd  = old;
        e_wen = (rd != 5'd0);
        src   = f3[2] ? {59'd0, rs1f} : rs1;
        case (f3[1:0])
          2'b10:   upd = old | src;
          2'b11:   upd = old & ~src;
          default: upd = src;
        endcase
        // set and clear with zero source are reads only
        if (f3[1:0] == 2'b01 || rs1f != 5'd0) begin
          case (idx)
            2'd0:    nx[0] = (old & ~sys_pkg::mstatus_wmask) | (upd & sys_pkg::mstatus_wmask);
            2'd3:    nx[3] = upd;
            default: nx[idx] = upd & sys_pkg::align_mask;
          endcase
        end
      end
    end
  endfunction

  // ************************************************************
  // checks
  // ************************************************************
  task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // outputs at the falling edge, debug view just after the rising edge
  initial begin : compare
    logic [3:0][63:0] model;
    logic [3:0][63:0] next_state;
    logic [63:0]      e_rd;
    logic [63:0]      e_rpc;
    logic             e_wen;
    logic             e_redir;
    logic             e_ill;
    logic             e_csr;
    model = {64'd0, 64'd0, 64'd0, sys_pkg::mstatus_reset};
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        predict(valid, inst, pc, rs1_data, model, next_state,
                e_rd, e_wen, e_redir, e_rpc, e_ill, e_csr);
        check_flag("illegal", illegal, e_ill);
        check_flag("redirect", redirect, e_redir);
        check_flag("rd_wen", rd_wen, e_wen);
        if (e_csr) check_word("rd_data", rd_data, e_rd);
        if (e_redir) check_word("redirect_pc", redirect_pc, e_rpc);
        @(posedge clk);
        #1;
        model = next_state;
        check_word("mstatus", mstatus, model[0]);
        check_word("mtvec", mtvec, model[1]);
        check_word("mepc", mepc, model[2]);
        check_word("mcause", mcause, model[3]);
      end
    end
  end

  // ************************************************************
  // stimulus
  // ************************************************************
  task automatic drive(input int kind);
    inst     = make_inst(kind);
    valid    = (kind != 6);
    pc       = {rand32(), rand32()};
    rs1_data = {rand32(), rand32()};
  endtask

  task automatic run_phase(input string name, input int kind, input int count);
    int err0;
    int chk0;
    err0 = errors;
    chk0 = checks;
    repeat (count) begin
      @(posedge clk);
      #2;
      drive((kind == 5) ? pick_kind() : kind);
    end
    // one idle slot, last state check lands at edge + 1 ns
    @(posedge clk);
    #2;
    drive(6);
    tests++;
    if (errors != err0) failed_tests++;
    $display("test %s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
  endtask

  initial begin : stimulus
    int waited;
    valid        = 1'b0;
    inst         = 32'd0;
    pc           = 64'd0;
    rs1_data     = 64'd0;
    seed         = 32'h543700e3;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    failed_tests = 0;
    waited       = 0;
    while (rst_n && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n) begin
      $display("timeout: reset never released");
      $display("Some tests failed");
      $finish;
    end else begin
      run_phase("reset values", 6, 4);
      run_phase("csr read-modify-write", 0, 200);
      run_phase("probes without side effects", 1, 60);
      run_phase("trap entry", 2, 20);
      run_phase("trap return", 3, 20);
      run_phase("illegal instructions", 4, 60);
      run_phase("random mix", 5, 600);
      repeat (2) @(posedge clk);
      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests, failed_tests, checks, errors);
      if (errors == 0) begin
        $display("All tests passed");
      end else begin
        $display("Some tests failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== build.f ====
logic/sys_pkg.sv
logic/csr_op_if.sv
logic/sys_decode.sv
logic/csr_alu.sv
logic/csr_file.sv
logic/sys_unit_top.sv
test/tb_clock.sv
test/tb_sys_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the system unit testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_sys_unit -f build.f -o sim_sys_unit
./obj_dir/sim_sys_unit > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation finished without failures"
